// ==== Makefile ====
SIM      := verilator
TOP      := cpuTb
FILELIST := src.f
OBJDIR   := obj_dir
FLAGS    := --binary -j 0 -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) include/tbProgram.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJDIR)

// ==== include/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam cpuPkg::word progBase = 32'h0000_3000;
localparam int progLength = 39;

// Argument order follows assembly, rd rs rt
function automatic cpuPkg::word encR(input logic [5:0] funct, input cpuPkg::regAddr rd,
                                     input cpuPkg::regAddr rs, input cpuPkg::regAddr rt);
    return {cpuPkg::opSpecial, rs, rt, rd, 5'd0, funct};
endfunction

// rt rs imm, also lw and sw with imm as offset
function automatic cpuPkg::word encI(input logic [5:0] op, input cpuPkg::regAddr rt,
                                     input cpuPkg::regAddr rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

localparam cpuPkg::word progImage [progLength] = '{
    encI(cpuPkg::opOri, 5'd1, 5'd0, 16'h1234),
    encI(cpuPkg::opLui, 5'd2, 5'd0, 16'h8000),
    encI(cpuPkg::opAddiu, 5'd3, 5'd0, 16'hfffb),
    encR(cpuPkg::fnAddu, 5'd4, 5'd1, 5'd3),
    encI(cpuPkg::opSw, 5'd4, 5'd0, 16'h0100),
    encR(cpuPkg::fnSubu, 5'd5, 5'd1, 5'd3),
    encI(cpuPkg::opSw, 5'd5, 5'd0, 16'h0104),
    encR(cpuPkg::fnAnd, 5'd6, 5'd1, 5'd3),
    encI(cpuPkg::opSw, 5'd6, 5'd0, 16'h0108),
    encR(cpuPkg::fnOr, 5'd7, 5'd2, 5'd1),
    encI(cpuPkg::opSw, 5'd7, 5'd0, 16'h010c),
    encR(cpuPkg::fnSlt, 5'd8, 5'd2, 5'd1),
    encI(cpuPkg::opSw, 5'd8, 5'd0, 16'h0110),
    encI(cpuPkg::opSw, 5'd3, 5'd0, 16'h0114),
    encI(cpuPkg::opSw, 5'd1, 5'd0, 16'h0118),
    encI(cpuPkg::opSw, 5'd2, 5'd0, 16'h011c),
    // Dependent chain through r9
    encI(cpuPkg::opAddiu, 5'd9, 5'd0, 16'h0001),
    encR(cpuPkg::fnAddu, 5'd9, 5'd9, 5'd9),
    encR(cpuPkg::fnAddu, 5'd9, 5'd9, 5'd9),
    encI(cpuPkg::opAddiu, 5'd9, 5'd9, 16'h0003),
    encR(cpuPkg::fnSubu, 5'd9, 5'd9, 5'd1),
    encI(cpuPkg::opSw, 5'd9, 5'd0, 16'h0120),
    // Load then immediate use
    encI(cpuPkg::opLw, 5'd10, 5'd0, 16'h0040),
    encI(cpuPkg::opAddiu, 5'd10, 5'd10, 16'h0055),
    encI(cpuPkg::opSw, 5'd10, 5'd0, 16'h0124),
    // Branches, each followed by its delay slot
    encI(cpuPkg::opBeq, 5'd0, 5'd0, 16'd2),
    encI(cpuPkg::opAddiu, 5'd11, 5'd0, 16'd7),
    encI(cpuPkg::opAddiu, 5'd11, 5'd0, 16'd99),
    encI(cpuPkg::opSw, 5'd11, 5'd0, 16'h0128),
    encI(cpuPkg::opBne, 5'd1, 5'd1, 16'd1),
    encI(cpuPkg::opAddiu, 5'd12, 5'd0, 16'd3),
    encI(cpuPkg::opBne, 5'd0, 5'd12, 16'd2),
    encI(cpuPkg::opAddiu, 5'd12, 5'd12, 16'd1),
    encI(cpuPkg::opAddiu, 5'd12, 5'd0, 16'd77),
    encI(cpuPkg::opBeq, 5'd1, 5'd12, 16'd1),
    encI(cpuPkg::opOri, 5'd12, 5'd12, 16'h0010),
    encI(cpuPkg::opSw, 5'd12, 5'd0, 16'h012c),
    32'h0000_0000,
    32'h0000_0000
};

localparam int storeCount = 12;
localparam cpuPkg::word expStoreAddr [storeCount] = '{
    32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114,
    32'h118, 32'h11c, 32'h120, 32'h124, 32'h128, 32'h12c
};
localparam cpuPkg::word expStoreData [storeCount] = '{
    32'h0000_122f, 32'h0000_1239, 32'h0000_1230, 32'h8000_1234,
    32'h0000_0001, 32'hffff_fffb, 32'h0000_1234, 32'h8000_0000,
    32'hffff_edd3, 32'h0000_0055, 32'h0000_0007, 32'h0000_0014
};

// This store expects the preloaded word at loadAddr plus its expStoreData entry
localparam int loadUseStore = 9;
localparam cpuPkg::word loadAddr = 32'h40;

// Program indices in retirement order, skipped ones left out
localparam int retireCount = 35;
localparam int retireIdx [retireCount] = '{
    0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17,
    18, 19, 20, 21, 22, 23, 24, 25, 26, 28, 29, 30, 31, 32, 34, 35, 36
};

function automatic cpuPkg::word expectedPc(input int k);
    return progBase + 32'(retireIdx[k] * 4);
endfunction

`endif

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    `include "tbProgram.svh"

    localparam int resetCycles = 4;
    localparam logic [15:0] lfsrSeed = 16'd13686;
    localparam int memWords = 256;

    logic clk;
    logic reset;
    cpuPkg::word instrAddress;
    cpuPkg::word instrData;
    cpuPkg::word effectivePC;
    logic sbWriteEnable;
    logic sbReadEnable;
    cpuPkg::word sbAddress;
    cpuPkg::word sbDataIn;
    cpuPkg::word sbDataOut;

    cpuPkg::word dataMem [memWords];
    cpuPkg::word loadedWord;
    cpuPkg::word expData;
    cpuPkg::word lastPc = '0;
    int storeIdx = 0;
    int retired = 0;
    int sinceReset = 0;

    cpuTop #(
        .resetVector(progBase)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .instrAddress(instrAddress),
        .instrData(instrData),
        .effectivePC(effectivePC),
        .sbWriteEnable(sbWriteEnable),
        .sbReadEnable(sbReadEnable),
        .sbAddress(sbAddress),
        .sbDataIn(sbDataIn),
        .sbDataOut(sbDataOut)
    );

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        return state >> 1;
    endfunction

    // Preload word at index, rebuilt from the seed
    function automatic cpuPkg::word fillWord(input int index);
        logic [15:0] state;
        cpuPkg::word value;
        state = lfsrSeed;
        value = '0;
        for (int n = 0; n < index * 32; n++) begin
            state = lfsrNext(state);
        end
        for (int b = 0; b < 32; b++) begin
            value = {value[30:0], state[0]};
            state = lfsrNext(state);
        end
        return value ^ cpuPkg::word'(index * 4);
    endfunction

    // Nop outside the program image
    function automatic cpuPkg::word programWord(input cpuPkg::word addr);
        cpuPkg::word offset;
        offset = addr - progBase;
        if (addr < progBase || offset[1:0] != 2'b00 ||
                offset >= cpuPkg::word'(progLength * 4))
            return 32'h0000_0000;
        return progImage[offset[7:2]];
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportMismatch(input string name, input cpuPkg::word expected,
                                  input cpuPkg::word actual);
        stopOnError($sformatf("Error %s expected %h got %h", name, expected, actual));
    endtask

    task automatic checkStore();
        if (storeIdx >= storeCount) begin
            stopOnError("a store appeared after the last expected store");
        end
        else begin
            expData = expStoreData[storeIdx];
            if (storeIdx == loadUseStore)
                expData = expData + loadedWord;
            assert (sbAddress == expStoreAddr[storeIdx])
                else reportMismatch("sbAddress", expStoreAddr[storeIdx], sbAddress);
            assert (sbDataIn == expData)
                else reportMismatch("sbDataIn", expData, sbDataIn);
            storeIdx++;
        end
    endtask

    task automatic checkRetire();
        assert (effectivePC == expectedPc(retired))
            else reportMismatch("effectivePC", expectedPc(retired), effectivePC);
        lastPc = effectivePC;
        retired++;
    endtask

    assign instrData = programWord(instrAddress);
    // Read data only while the read is enabled
    assign sbDataOut = sbReadEnable ? dataMem[sbAddress[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        logic [15:0] state;
        cpuPkg::word value;
        state = lfsrSeed;
        for (int i = 0; i < memWords; i++) begin
            value = '0;
            for (int b = 0; b < 32; b++) begin
                value = {value[30:0], state[0]};
                state = lfsrNext(state);
            end
            dataMem[i] = value ^ cpuPkg::word'(i * 4);
        end
    end

    always @(posedge clk) begin
        if (sbWriteEnable)
            dataMem[sbAddress[9:2]] <= sbDataIn;
    end

    // Mid-cycle sampling, outputs settled
    always @(negedge clk) begin
        if (!reset) begin
            sinceReset++;
            if (sinceReset == 1) begin
                assert (instrAddress == progBase)
                    else reportMismatch("instrAddress", progBase, instrAddress);
            end
            if (sinceReset <= 5) begin
                assert (effectivePC == 32'h0)
                    else reportMismatch("effectivePC", 32'h0, effectivePC);
            end
            if (storeIdx == 0) begin
                assert (!sbReadEnable)
                    else stopOnError("sbReadEnable went high before the first store");
            end
            if (sbWriteEnable)
                checkStore();
            if (retired < retireCount && effectivePC != lastPc)
                checkRetire();
        end
    end

    initial begin
        reset = 1'b1;
        loadedWord = fillWord(int'(loadAddr >> 2));
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        while (storeIdx < storeCount || retired < retireCount) begin
            @(posedge clk);
        end
        $display("Test OK");
        $finish;
    end

    // Ten cycles per program word
    initial begin
        repeat (resetCycles + progLength * 10) @(posedge clk);
        stopOnError("the program did not finish before the watchdog limit");
    end

endmodule

// ==== src.f ====
+incdir+include
verilog/cpuPkg.sv
verilog/pipeIf.sv
verilog/fetchStage.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWritebackStage.sv
verilog/cpuTop.sv
dv/cpuTb.sv

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word;
    typedef logic [4:0] regAddr;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr rs;
        regAddr rt;
        regAddr rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr rs;
        regAddr rt;
        logic [15:0] imm;
    } iFormat;

    // One fetched word, two views
    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // R-format function codes
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

endpackage

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
    parameter cpuPkg::word resetVector = '0
) (
    input logic clk,
    input logic reset,
    output cpuPkg::word instrAddress,
    input cpuPkg::word instrData,
    output cpuPkg::word effectivePC,
    output logic sbWriteEnable,
    output logic sbReadEnable,
    output cpuPkg::word sbAddress,
    output cpuPkg::word sbDataIn,
    input cpuPkg::word sbDataOut
);

    fetchIf fetchBus();
    execIf execBus();
    memIf memBus();

    logic fwdMemValid;
    cpuPkg::regAddr fwdMemReg;
    cpuPkg::word fwdMemValue;
    logic memIsLoad;
    logic wbEnable;
    cpuPkg::regAddr wbReg;
    cpuPkg::word wbData;

    fetchStage #(
        .resetVector(resetVector)
    ) fetchUnit (
        .clk(clk),
        .reset(reset),
        .instrAddress(instrAddress),
        .instrData(instrData),
        .fetch(fetchBus.fetcher)
    );

    decodeStage decodeUnit (
        .clk(clk),
        .reset(reset),
        .fetch(fetchBus.decoder),
        .exec(execBus.decoder),
        .fwdMemValid(fwdMemValid),
        .fwdMemReg(fwdMemReg),
        .fwdMemValue(fwdMemValue),
        .memIsLoad(memIsLoad),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    executeStage executeUnit (
        .clk(clk),
        .reset(reset),
        .exec(execBus.executor),
        .mem(memBus.executor)
    );

    memWritebackStage memUnit (
        .clk(clk),
        .reset(reset),
        .mem(memBus.memory),
        .sbWriteEnable(sbWriteEnable),
        .sbReadEnable(sbReadEnable),
        .sbAddress(sbAddress),
        .sbDataIn(sbDataIn),
        .sbDataOut(sbDataOut),
        .fwdMemValid(fwdMemValid),
        .fwdMemReg(fwdMemReg),
        .fwdMemValue(fwdMemValue),
        .memIsLoad(memIsLoad),
        .wbEnable(wbEnable),
        .wbReg(wbReg),
        .wbData(wbData),
        .effectivePC(effectivePC)
    );

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input logic clk,
    input logic reset,
    fetchIf.decoder fetch,
    execIf.decoder exec,
    input logic fwdMemValid,
    input cpuPkg::regAddr fwdMemReg,
    input cpuPkg::word fwdMemValue,
    input logic memIsLoad,
    input logic wbEnable,
    input cpuPkg::regAddr wbReg,
    input cpuPkg::word wbData
);

    cpuPkg::instrWord ins;
    cpuPkg::word signImm;
    cpuPkg::word zeroImm;
    cpuPkg::word rfData1;
    cpuPkg::word rfData2;
    cpuPkg::word rsValue;
    cpuPkg::word rtValue;
    cpuPkg::aluOp op;
    cpuPkg::regAddr destReg;
    logic useRs;
    logic useRt;
    logic useImm;
    logic immZeroExt;
    logic isBranch;
    logic memLoad;
    logic memStore;
    // Destination of whatever sits in execute now
    cpuPkg::regAddr execReg;
    logic hazardExec;
    logic hazardLoad;
    logic stall;
    logic taken;

    function automatic logic sourceMatch(input cpuPkg::regAddr r);
        return r != '0 && ((useRs && ins.i.rs == r) || (useRt && ins.i.rt == r));
    endfunction

    assign ins = fetch.instr;
    assign signImm = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign zeroImm = {16'b0, ins.i.imm};

    always_comb begin
        op = cpuPkg::aluAdd;
        destReg = '0;
        useRs = 1'b1;
        useRt = 1'b0;
        useImm = 1'b1;
        immZeroExt = 1'b0;
        isBranch = 1'b0;
        memLoad = 1'b0;
        memStore = 1'b0;
        case (ins.i.opcode)
            cpuPkg::opSpecial: begin
                useRt = 1'b1;
                useImm = 1'b0;
                destReg = ins.r.rd;
                case (ins.r.funct)
                    cpuPkg::fnAddu: op = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: op = cpuPkg::aluSub;
                    cpuPkg::fnAnd: op = cpuPkg::aluAnd;
                    cpuPkg::fnOr: op = cpuPkg::aluOr;
                    cpuPkg::fnSlt: op = cpuPkg::aluSlt;
                    // Anything else, nop included, writes nothing
                    default: destReg = '0;
                endcase
            end
            cpuPkg::opAddiu: destReg = ins.i.rt;
            cpuPkg::opOri: begin
                op = cpuPkg::aluOr;
                immZeroExt = 1'b1;
                destReg = ins.i.rt;
            end
            cpuPkg::opLui: begin
                op = cpuPkg::aluLui;
                useRs = 1'b0;
                immZeroExt = 1'b1;
                destReg = ins.i.rt;
            end
            cpuPkg::opLw: begin
                memLoad = 1'b1;
                destReg = ins.i.rt;
            end
            cpuPkg::opSw: begin
                memStore = 1'b1;
                useRt = 1'b1;
            end
            cpuPkg::opBeq, cpuPkg::opBne: begin
                isBranch = 1'b1;
                useRt = 1'b1;
            end
            default: useRs = 1'b0;
        endcase
    end

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .readAddr1(ins.i.rs),
        .readAddr2(ins.i.rt),
        .readData1(rfData1),
        .readData2(rfData2),
        .writeEnable(wbEnable),
        .writeAddr(wbReg),
        .writeData(wbData)
    );

    // Memory stage wins over the writeback path inside the register file
    assign rsValue = (fwdMemValid && fwdMemReg == ins.i.rs) ? fwdMemValue : rfData1;
    assign rtValue = (fwdMemValid && fwdMemReg == ins.i.rt) ? fwdMemValue : rfData2;

    always_comb begin
        hazardExec = sourceMatch(execReg);
        hazardLoad = memIsLoad && sourceMatch(fwdMemReg);
    end

    assign stall = fetch.valid && (hazardExec || hazardLoad);
    assign taken = (rsValue == rtValue) != (ins.i.opcode == cpuPkg::opBne);

    assign fetch.stall = stall;
    assign fetch.redirect = fetch.valid && isBranch && taken && !stall;
    assign fetch.redirectTarget = fetch.pc + 32'd4 + {signImm[29:0], 2'b00};

    assign exec.valid = fetch.valid && !stall;
    assign exec.op = op;
    assign exec.operandA = rsValue;
    assign exec.operandB = useImm ? (immZeroExt ? zeroImm : signImm) : rtValue;
    assign exec.destReg = destReg;
    assign exec.memLoad = memLoad;
    assign exec.memStore = memStore;
    assign exec.storeData = rtValue;
    assign exec.pc = fetch.pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            execReg <= '0;
        end
        else begin
            execReg <= exec.valid ? exec.destReg : '0;
        end
    end

    // Delay slot enters decode right after a taken branch
    delaySlotNext: assert property (@(posedge clk) disable iff (reset)
        fetch.redirect |=> (fetch.valid && fetch.pc == $past(fetch.pc) + 32'd4))
        else $error("delay slot missing after branch at %h", $past(fetch.pc));

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input logic clk,
    input logic reset,
    execIf.executor exec,
    memIf.executor mem
);

    logic valid;
    cpuPkg::aluOp opReg;
    cpuPkg::word aReg;
    cpuPkg::word bReg;
    cpuPkg::regAddr destReg;
    logic loadReg;
    logic storeReg;
    cpuPkg::word storeDataReg;
    cpuPkg::word pcReg;
    cpuPkg::word result;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end
        else begin
            valid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        opReg <= exec.op;
        aReg <= exec.operandA;
        bReg <= exec.operandB;
        destReg <= exec.destReg;
        loadReg <= exec.memLoad;
        storeReg <= exec.memStore;
        storeDataReg <= exec.storeData;
        pcReg <= exec.pc;
    end

    always_comb begin
        case (opReg)
            cpuPkg::aluSub: result = aReg - bReg;
            cpuPkg::aluAnd: result = aReg & bReg;
            cpuPkg::aluOr: result = aReg | bReg;
            cpuPkg::aluSlt: result = {31'b0, $signed(aReg) < $signed(bReg)};
            cpuPkg::aluLui: result = {bReg[15:0], 16'b0};
            default: result = aReg + bReg;
        endcase
    end

    assign mem.valid = valid;
    assign mem.result = result;
    assign mem.destReg = destReg;
    assign mem.memLoad = loadReg;
    assign mem.memStore = storeReg;
    assign mem.storeData = storeDataReg;
    assign mem.pc = pcReg;

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
    parameter cpuPkg::word resetVector = '0
) (
    input logic clk,
    input logic reset,
    output cpuPkg::word instrAddress,
    input cpuPkg::word instrData,
    fetchIf.fetcher fetch
);

    cpuPkg::word pc;

    assign instrAddress = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end
        else if (!fetch.stall) begin
            pc <= fetch.redirect ? fetch.redirectTarget : pc + 32'd4;
        end
    end

    // Decode register, empty only right after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end
        else if (!fetch.stall) begin
            fetch.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch.stall) begin
            fetch.instr <= instrData;
            fetch.pc <= pc;
        end
    end

    addrAligned: assert property (@(posedge clk) disable iff (reset)
        instrAddress[1:0] == 2'b00)
        else $error("instrAddress %h not word aligned", instrAddress);

endmodule

// ==== verilog/memWritebackStage.sv ====
`timescale 1ns/1ps

module memWritebackStage (
    input logic clk,
    input logic reset,
    memIf.memory mem,
    output logic sbWriteEnable,
    output logic sbReadEnable,
    output cpuPkg::word sbAddress,
    output cpuPkg::word sbDataIn,
    input cpuPkg::word sbDataOut,
    output logic fwdMemValid,
    output cpuPkg::regAddr fwdMemReg,
    output cpuPkg::word fwdMemValue,
    output logic memIsLoad,
    output logic wbEnable,
    output cpuPkg::regAddr wbReg,
    output cpuPkg::word wbData,
    output cpuPkg::word effectivePC
);

    logic memValid;
    cpuPkg::word memResult;
    cpuPkg::regAddr memDest;
    logic memLoad;
    logic memStore;
    cpuPkg::word memStoreData;
    cpuPkg::word memPc;
    logic wbValid;
    cpuPkg::regAddr wbDest;
    cpuPkg::word wbValue;
    cpuPkg::word wbPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid <= 1'b0;
            wbValid <= 1'b0;
            effectivePC <= '0;
        end
        else begin
            memValid <= mem.valid;
            wbValid <= memValid;
            if (wbValid) begin
                effectivePC <= wbPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        memResult <= mem.result;
        memDest <= mem.destReg;
        memLoad <= mem.memLoad;
        memStore <= mem.memStore;
        memStoreData <= mem.storeData;
        memPc <= mem.pc;
        wbDest <= memDest;
        // Bus answers in the same cycle
        wbValue <= memLoad ? sbDataOut : memResult;
        wbPc <= memPc;
    end

    assign sbReadEnable = memValid && memLoad;
    assign sbWriteEnable = memValid && memStore;
    assign sbAddress = memResult;
    assign sbDataIn = memStoreData;

    // Load data is not here yet, decode stalls on it instead
    assign fwdMemValid = memValid && !memLoad && memDest != '0;
    assign fwdMemReg = memDest;
    assign fwdMemValue = memResult;
    assign memIsLoad = memValid && memLoad;

    assign wbEnable = wbValid && wbDest != '0;
    assign wbReg = wbDest;
    assign wbData = wbValue;

    busExclusive: assert property (@(posedge clk) disable iff (reset)
        !(sbReadEnable && sbWriteEnable))
        else $error("sbReadEnable and sbWriteEnable high together at pc %h", memPc);

endmodule

// ==== verilog/pipeIf.sv ====
`timescale 1ns/1ps

interface fetchIf;
    cpuPkg::word instr;
    cpuPkg::word pc;
    logic valid;
    logic stall;
    logic redirect;
    cpuPkg::word redirectTarget;

    modport fetcher(output instr, pc, valid, input stall, redirect, redirectTarget);
    modport decoder(input instr, pc, valid, output stall, redirect, redirectTarget);
endinterface

interface execIf;
    logic valid;
    cpuPkg::aluOp op;
    cpuPkg::word operandA;
    cpuPkg::word operandB;
    cpuPkg::regAddr destReg;
    logic memLoad;
    logic memStore;
    cpuPkg::word storeData;
    cpuPkg::word pc;

    modport decoder(output valid, op, operandA, operandB, destReg, memLoad, memStore,
                    storeData, pc);
    modport executor(input valid, op, operandA, operandB, destReg, memLoad, memStore,
                     storeData, pc);
endinterface

interface memIf;
    logic valid;
    cpuPkg::word result;
    cpuPkg::regAddr destReg;
    logic memLoad;
    logic memStore;
    cpuPkg::word storeData;
    cpuPkg::word pc;

    modport executor(output valid, result, destReg, memLoad, memStore, storeData, pc);
    modport memory(input valid, result, destReg, memLoad, memStore, storeData, pc);
endinterface

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input logic clk,
    input logic reset,
    input cpuPkg::regAddr readAddr1,
    input cpuPkg::regAddr readAddr2,
    output cpuPkg::word readData1,
    output cpuPkg::word readData2,
    input logic writeEnable,
    input cpuPkg::regAddr writeAddr,
    input cpuPkg::word writeData
);

    cpuPkg::word regs [32];

    // Write-through so decode sees the value being retired this cycle
    function automatic cpuPkg::word readPort(input cpuPkg::regAddr addr);
        if (addr == '0)
            return '0;
        if (writeEnable && writeAddr == addr)
            return writeData;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule
